//--- src/txn_mux_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, ID types and request/response structs for
// the transaction multiplexer. Modules refer to these by
// scoped names.
////////////////////////////////////////////////////////////

`default_nettype none

package txn_mux_pkg;

  localparam int unsigned NUM_PORTS_MAX  = 4;
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned UP_ID_WIDTH    = 2;
  localparam int unsigned PORT_SEL_WIDTH = $clog2(NUM_PORTS_MAX);
  localparam int unsigned MUX_ID_WIDTH   = PORT_SEL_WIDTH + UP_ID_WIDTH;  // Port prefix + ID
  localparam int unsigned DN_ID_WIDTH    = 2;  // Also sets remap slot count

  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [UP_ID_WIDTH-1:0]  up_id_t;
  typedef logic [MUX_ID_WIDTH-1:0] mux_id_t;
  typedef logic [DN_ID_WIDTH-1:0]  dn_id_t;

  // Upstream port side
  typedef struct packed {
    up_id_t id;
    addr_t  addr;
    data_t  wdata;
    logic   write;
  } up_req_t;

  typedef struct packed {
    up_id_t id;
    data_t  rdata;
  } up_rsp_t;

  // Between arbiter and remapper the ID carries the source port
  typedef struct packed {
    mux_id_t id;
    addr_t   addr;
    data_t   wdata;
    logic    write;
  } mux_req_t;

  typedef struct packed {
    mux_id_t id;
    data_t   rdata;
  } mux_rsp_t;

  // Downstream port side
  typedef struct packed {
    dn_id_t id;
    addr_t  addr;
    data_t  wdata;
    logic   write;
  } dn_req_t;

  typedef struct packed {
    dn_id_t id;
    data_t  rdata;
  } dn_rsp_t;

endpackage

`default_nettype wire

//--- src/port_arbiter.sv
////////////////////////////////////////////////////////////
// Merges the upstream request ports onto one link with a
// round-robin grant and puts the port number in front of
// the ID. Responses are steered back by that prefix.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module port_arbiter #(
  parameter int unsigned NumPorts = 4
) (
  input  wire                                      periph_clk,
  input  wire                                      reset_i,
  // Upstream ports
  input  wire  [NumPorts-1:0]                      up_req_valid_i,
  input  txn_mux_pkg::up_req_t [NumPorts-1:0]      up_req_i,
  output logic [NumPorts-1:0]                      up_req_ready_o,
  output logic [NumPorts-1:0]                      up_rsp_valid_o,
  output txn_mux_pkg::up_rsp_t [NumPorts-1:0]      up_rsp_o,
  input  wire  [NumPorts-1:0]                      up_rsp_ready_i,
  // Merged link
  output logic                                     mux_req_valid_o,
  output txn_mux_pkg::mux_req_t                    mux_req_o,
  input  wire                                      mux_req_ready_i,
  input  wire                                      mux_rsp_valid_i,
  input  txn_mux_pkg::mux_rsp_t                    mux_rsp_i,
  output logic                                     mux_rsp_ready_o
);

  typedef logic [txn_mux_pkg::PORT_SEL_WIDTH-1:0] port_sel_t;

  port_sel_t last_q;     // Last port that transferred
  port_sel_t grant_idx;
  logic      grant_vld;
  port_sel_t rsp_port;
  logic [NumPorts-1:0] rsp_sel;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Search starts one past the last winner
  always_comb begin
    int unsigned idx;
    grant_idx = last_q;
    grant_vld = 1'b0;
    for (int unsigned i = 1; i <= NumPorts; i++) begin
      idx = (int'(last_q) + i) % NumPorts;
      if (!grant_vld && up_req_valid_i[idx]) begin
        grant_vld = 1'b1;
        grant_idx = port_sel_t'(idx);
      end
    end
  end

  assign mux_req_valid_o = grant_vld;
  assign mux_req_o = '{
    id:    {grant_idx, up_req_i[grant_idx].id},
    addr:  up_req_i[grant_idx].addr,
    wdata: up_req_i[grant_idx].wdata,
    write: up_req_i[grant_idx].write
  };

  always_comb begin
    for (int unsigned i = 0; i < NumPorts; i++) begin
      up_req_ready_o[i] = grant_vld && (grant_idx == port_sel_t'(i)) && mux_req_ready_i;
    end
  end

  always_ff @(posedge periph_clk) begin
    if (reset_i) begin
      last_q <= port_sel_t'(NumPorts - 1);  // Port 0 wins first
    end else if (mux_req_valid_o && mux_req_ready_i) begin
      last_q <= grant_idx;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  assign rsp_port = mux_rsp_i.id[txn_mux_pkg::MUX_ID_WIDTH-1 -: txn_mux_pkg::PORT_SEL_WIDTH];

  always_comb begin
    for (int unsigned i = 0; i < NumPorts; i++) begin
      rsp_sel[i]     = (rsp_port == port_sel_t'(i));
      up_rsp_o[i]    = '{id: mux_rsp_i.id[txn_mux_pkg::UP_ID_WIDTH-1:0],
                         rdata: mux_rsp_i.rdata};  // Prefix stripped
      up_rsp_valid_o[i] = mux_rsp_valid_i && rsp_sel[i];
    end
  end

  assign mux_rsp_ready_o = |(rsp_sel & up_rsp_ready_i);

  // Restored ID from the remapper must name a real port
  assert property (@(posedge periph_clk) disable iff (reset_i)
    mux_rsp_valid_i |-> (int'(rsp_port) < NumPorts))
    else $error("response prefix %0d names no upstream port", rsp_port);

endmodule

`default_nettype wire

//--- src/id_remap.sv
////////////////////////////////////////////////////////////
// Shrinks the wide merged ID to a narrow downstream ID.
// Each slot holds one wide ID and a count of transactions
// in flight; the slot index is the downstream ID. Responses
// get their wide ID back from the table.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module id_remap #(
  parameter int unsigned MaxTxnsPerId = 3
) (
  input  wire                   periph_clk,
  input  wire                   reset_i,
  // Merged link from the arbiter
  input  wire                   mux_req_valid_i,
  input  txn_mux_pkg::mux_req_t mux_req_i,
  output logic                  mux_req_ready_o,
  output logic                  mux_rsp_valid_o,
  output txn_mux_pkg::mux_rsp_t mux_rsp_o,
  input  wire                   mux_rsp_ready_i,
  // Downstream port
  output logic                  dn_req_valid_o,
  output txn_mux_pkg::dn_req_t  dn_req_o,
  input  wire                   dn_req_ready_i,
  input  wire                   dn_rsp_valid_i,
  input  txn_mux_pkg::dn_rsp_t  dn_rsp_i,
  output logic                  dn_rsp_ready_o
);

  localparam int unsigned NumSlots = 2 ** txn_mux_pkg::DN_ID_WIDTH;
  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  txn_mux_pkg::mux_id_t slot_id_q  [NumSlots];  // Wide ID per slot
  cnt_t                 slot_cnt_q [NumSlots];  // Zero means free

  logic                match_vld;
  txn_mux_pkg::dn_id_t match_idx;
  logic                free_vld;
  txn_mux_pkg::dn_id_t free_idx;
  txn_mux_pkg::dn_id_t sel_idx;
  logic                slot_ok;
  logic                req_fire;
  logic                rsp_fire;

  ////////////////////////////////////////////////////////////
  // Slot lookup
  ////////////////////////////////////////////////////////////

  always_comb begin
    match_vld = 1'b0;
    match_idx = '0;
    free_vld  = 1'b0;
    free_idx  = '0;
    // Walk downward so the lowest free slot wins
    for (int s = NumSlots - 1; s >= 0; s--) begin
      if (slot_cnt_q[s] == '0) begin
        free_vld = 1'b1;
        free_idx = txn_mux_pkg::dn_id_t'(s);
      end else if (slot_id_q[s] == mux_req_i.id) begin
        match_vld = 1'b1;
        match_idx = txn_mux_pkg::dn_id_t'(s);
      end
    end
  end

  // Same ID stays in its slot to keep per-ID order
  assign sel_idx = match_vld ? match_idx : free_idx;
  assign slot_ok = match_vld ? (slot_cnt_q[match_idx] != cnt_t'(MaxTxnsPerId)) : free_vld;

  assign dn_req_valid_o  = mux_req_valid_i && slot_ok;
  assign mux_req_ready_o = dn_req_ready_i && slot_ok;
  assign req_fire        = mux_req_valid_i && mux_req_ready_o;

  assign dn_req_o = '{
    id:    sel_idx,
    addr:  mux_req_i.addr,
    wdata: mux_req_i.wdata,
    write: mux_req_i.write
  };

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  assign mux_rsp_valid_o = dn_rsp_valid_i;
  assign mux_rsp_o       = '{id: slot_id_q[dn_rsp_i.id], rdata: dn_rsp_i.rdata};
  assign dn_rsp_ready_o  = mux_rsp_ready_i;
  assign rsp_fire        = dn_rsp_valid_i && mux_rsp_ready_i;

  ////////////////////////////////////////////////////////////
  // Table update
  ////////////////////////////////////////////////////////////

  for (genvar s = 0; s < NumSlots; s++) begin : gen_slot
    logic inc;
    logic dec;

    assign inc = req_fire && (sel_idx == txn_mux_pkg::dn_id_t'(s));
    assign dec = rsp_fire && (dn_rsp_i.id == txn_mux_pkg::dn_id_t'(s));

    always_ff @(posedge periph_clk) begin
      if (reset_i) begin
        slot_cnt_q[s] <= '0;
      end else if (inc && !dec) begin
        slot_cnt_q[s] <= slot_cnt_q[s] + cnt_t'(1);
      end else if (dec && !inc) begin
        slot_cnt_q[s] <= slot_cnt_q[s] - cnt_t'(1);
      end
    end

    always_ff @(posedge periph_clk) begin
      if (inc) begin
        slot_id_q[s] <= mux_req_i.id;  // Same value on reuse
      end
    end

    // A full slot never takes one more
    assert property (@(posedge periph_clk) disable iff (reset_i)
      (inc && !dec) |-> (slot_cnt_q[s] < cnt_t'(MaxTxnsPerId)))
      else $error("slot %0d grows past %0d transactions", s, MaxTxnsPerId);
  end

  // Downstream must only answer IDs that were issued
  assert property (@(posedge periph_clk) disable iff (reset_i)
    dn_rsp_valid_i |-> (slot_cnt_q[dn_rsp_i.id] != '0))
    else $error("response for idle downstream ID %0d", dn_rsp_i.id);

endmodule

`default_nettype wire

//--- src/txn_mux_top.sv
////////////////////////////////////////////////////////////
// Top level of the transaction multiplexer. Joins the port
// arbiter and the ID remapper and sets the port count and
// the per-ID transaction limit.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module txn_mux_top #(
  parameter int unsigned NumPorts     = 4,
  parameter int unsigned MaxTxnsPerId = 3
) (
  input  wire                                  periph_clk,
  input  wire                                  reset_i,
  // Upstream ports
  input  wire  [NumPorts-1:0]                  up_req_valid_i,
  input  txn_mux_pkg::up_req_t [NumPorts-1:0]  up_req_i,
  output logic [NumPorts-1:0]                  up_req_ready_o,
  output logic [NumPorts-1:0]                  up_rsp_valid_o,
  output txn_mux_pkg::up_rsp_t [NumPorts-1:0]  up_rsp_o,
  input  wire  [NumPorts-1:0]                  up_rsp_ready_i,
  // Downstream port
  output logic                                 dn_req_valid_o,
  output txn_mux_pkg::dn_req_t                 dn_req_o,
  input  wire                                  dn_req_ready_i,
  input  wire                                  dn_rsp_valid_i,
  input  txn_mux_pkg::dn_rsp_t                 dn_rsp_i,
  output logic                                 dn_rsp_ready_o
);

  // Merged link between arbiter and remapper
  logic                  mux_req_valid;
  txn_mux_pkg::mux_req_t mux_req;
  logic                  mux_req_ready;
  logic                  mux_rsp_valid;
  txn_mux_pkg::mux_rsp_t mux_rsp;
  logic                  mux_rsp_ready;

  port_arbiter #(
    .NumPorts ( NumPorts )
  ) i_port_arbiter (
    .periph_clk      ( periph_clk     ),
    .reset_i         ( reset_i        ),
    .up_req_valid_i  ( up_req_valid_i ),
    .up_req_i        ( up_req_i       ),
    .up_req_ready_o  ( up_req_ready_o ),
    .up_rsp_valid_o  ( up_rsp_valid_o ),
    .up_rsp_o        ( up_rsp_o       ),
    .up_rsp_ready_i  ( up_rsp_ready_i ),
    .mux_req_valid_o ( mux_req_valid  ),
    .mux_req_o       ( mux_req        ),
    .mux_req_ready_i ( mux_req_ready  ),
    .mux_rsp_valid_i ( mux_rsp_valid  ),
    .mux_rsp_i       ( mux_rsp        ),
    .mux_rsp_ready_o ( mux_rsp_ready  )
  );

  id_remap #(
    .MaxTxnsPerId ( MaxTxnsPerId )
  ) i_id_remap (
    .periph_clk      ( periph_clk     ),
    .reset_i         ( reset_i        ),
    .mux_req_valid_i ( mux_req_valid  ),
    .mux_req_i       ( mux_req        ),
    .mux_req_ready_o ( mux_req_ready  ),
    .mux_rsp_valid_o ( mux_rsp_valid  ),
    .mux_rsp_o       ( mux_rsp        ),
    .mux_rsp_ready_i ( mux_rsp_ready  ),
    .dn_req_valid_o  ( dn_req_valid_o ),
    .dn_req_o        ( dn_req_o       ),
    .dn_req_ready_i  ( dn_req_ready_i ),
    .dn_rsp_valid_i  ( dn_rsp_valid_i ),
    .dn_rsp_i        ( dn_rsp_i       ),
    .dn_rsp_ready_o  ( dn_rsp_ready_o )
  );

endmodule

`default_nettype wire

//--- testbench/tb_txn_mux.sv
////////////////////////////////////////////////////////////
// Testbench for the transaction multiplexer. Random traffic
// on every upstream port, a downstream responder that may
// reorder across IDs, and concurrent checks on the results.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_txn_mux;

  localparam int NUM_PORTS      = 4;
  localparam int UP_IDS         = 4;
  localparam int NUM_SLOTS      = 4;
  localparam int MAX_TXNS       = 3;
  localparam int REQS_PER_PORT  = 40;
  localparam int TOTAL_REQS     = REQS_PER_PORT * NUM_PORTS;
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * 20;
  localparam int NUM_KEYS       = NUM_PORTS * UP_IDS;  // One queue per port and ID

  logic                                 periph_clk;
  logic                                 reset_i = 1'b1;
  logic [NUM_PORTS-1:0]                 up_req_valid_i = '0;
  txn_mux_pkg::up_req_t [NUM_PORTS-1:0] up_req_i = '0;
  logic [NUM_PORTS-1:0]                 up_rsp_ready_i = '0;
  logic [NUM_PORTS-1:0]                 up_req_ready_o;
  logic [NUM_PORTS-1:0]                 up_rsp_valid_o;
  txn_mux_pkg::up_rsp_t [NUM_PORTS-1:0] up_rsp_o;
  logic                                 dn_req_ready_i = 1'b0;
  logic                                 dn_rsp_valid_i = 1'b0;
  txn_mux_pkg::dn_rsp_t                 dn_rsp_i = '0;
  logic                                 dn_req_valid_o;
  logic                                 dn_rsp_ready_o;
  txn_mux_pkg::dn_req_t                 dn_req_o;

  int                 seed = 32'h51aec340;
  int                 cycles = 0;
  int                 errors = 0;
  int                 rsp_count = 0;
  int                 issued [NUM_PORTS] = '{default: 0};
  int                 exp_head [NUM_KEYS] = '{default: 0};
  int                 exp_tail [NUM_KEYS] = '{default: 0};
  txn_mux_pkg::data_t exp_rdata [NUM_KEYS][REQS_PER_PORT];  // Expected rdata in issue order
  txn_mux_pkg::data_t rsp_q [NUM_SLOTS][$];                 // Responder backlog per ID
  int                 up_fires;
  int                 busy_pairs;
  int                 max_depth;
  logic               req_ok;
  logic               rsp_ok;
  logic               timed_out;

  txn_mux_top dut0 (.*);

  initial begin
    periph_clk = 1'b0;
    forever #10 periph_clk = ~periph_clk;
  end

  always @(posedge periph_clk) begin
    cycles <= cycles + 1;
  end

  task automatic report_mismatch(input string what);
    errors = errors + 1;
    $display("MISMATCH %0t: %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and responder model
  ////////////////////////////////////////////////////////////

  always @(posedge periph_clk) begin
    int key;
    int n_rsp;
    txn_mux_pkg::dn_id_t pick;
    n_rsp = 0;
    if (!reset_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (up_req_valid_i[p] && up_req_ready_o[p]) begin
          key = p * UP_IDS + int'(up_req_i[p].id);
          exp_rdata[key][exp_tail[key]] <= up_req_i[p].addr ^ up_req_i[p].wdata;
          exp_tail[key] <= exp_tail[key] + 1;
        end
        if (up_rsp_valid_o[p] && up_rsp_ready_i[p]) begin
          key = p * UP_IDS + int'(up_rsp_o[p].id);
          exp_head[key] <= exp_head[key] + 1;
          n_rsp++;
        end
        // Hold until transfer then maybe offer the next one
        if (!up_req_valid_i[p] || up_req_ready_o[p]) begin
          up_req_valid_i[p] <= 1'b0;
          if (issued[p] < REQS_PER_PORT && 1'($random(seed))) begin
            up_req_valid_i[p] <= 1'b1;
            up_req_i[p] <= '{id: txn_mux_pkg::up_id_t'($random(seed)), addr: $random(seed),
                             wdata: $random(seed), write: 1'($random(seed))};
            issued[p] <= issued[p] + 1;
          end
        end
      end
      rsp_count      <= rsp_count + n_rsp;
      dn_req_ready_i <= 1'($random(seed));
      up_rsp_ready_i <= NUM_PORTS'($random(seed));
      if (dn_req_valid_o && dn_req_ready_i) begin
        rsp_q[dn_req_o.id].push_back(dn_req_o.addr ^ dn_req_o.wdata);
      end
      if (dn_rsp_valid_i && dn_rsp_ready_o) begin
        void'(rsp_q[dn_rsp_i.id].pop_front());
      end
      // Oldest entry of a random ID with a backlog
      if (!dn_rsp_valid_i || dn_rsp_ready_o) begin
        dn_rsp_valid_i <= 1'b0;
        pick = txn_mux_pkg::dn_id_t'($random(seed));
        for (int i = 0; i < NUM_SLOTS; i++) begin
          if (rsp_q[pick].size() == 0) begin
            pick = pick + txn_mux_pkg::dn_id_t'(1);
          end
        end
        if (rsp_q[pick].size() != 0 && 1'($random(seed))) begin
          dn_rsp_valid_i <= 1'b1;
          dn_rsp_i       <= '{id: pick, rdata: rsp_q[pick][0]};
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard checks
  ////////////////////////////////////////////////////////////

  always_comb begin
    int key;
    key        = 0;
    up_fires   = 0;
    req_ok     = 1'b0;
    rsp_ok     = 1'b1;
    busy_pairs = 0;
    max_depth  = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      key = p * UP_IDS + int'(up_rsp_o[p].id);
      if (up_req_valid_i[p] && up_req_ready_o[p]) begin
        up_fires++;
        req_ok = (dn_req_o.addr == up_req_i[p].addr) && (dn_req_o.wdata == up_req_i[p].wdata)
                 && (dn_req_o.write == up_req_i[p].write);
      end
      if (up_rsp_valid_o[p] && up_rsp_ready_i[p] && ((exp_head[key] == exp_tail[key])
          || (exp_rdata[key][exp_head[key]] != up_rsp_o[p].rdata))) begin
        rsp_ok = 1'b0;  // Wrong port, ID, order or data
      end
    end
    for (int k = 0; k < NUM_KEYS; k++) begin
      if (exp_tail[k] != exp_head[k]) begin
        busy_pairs++;
      end
      if (exp_tail[k] - exp_head[k] > max_depth) begin
        max_depth = exp_tail[k] - exp_head[k];
      end
    end
  end

  assert property (@(posedge periph_clk) disable iff (reset_i)
    ((dn_req_valid_o && dn_req_ready_i) || up_fires != 0) |->
      (dn_req_valid_o && dn_req_ready_i && up_fires == 1 && req_ok))
    else report_mismatch("downstream request differs from the upstream transfer");

  assert property (@(posedge periph_clk) disable iff (reset_i) rsp_ok)
    else report_mismatch("upstream response on wrong port, out of order or bad rdata");

  assert property (@(posedge periph_clk) disable iff (reset_i)
    busy_pairs <= NUM_SLOTS && max_depth <= MAX_TXNS)
    else report_mismatch("too many transactions in flight");

  assert property (@(posedge periph_clk)
    (reset_i || $fell(reset_i)) |-> (!dn_req_valid_o && up_rsp_valid_o == '0))
    else report_mismatch("valid output raised during or right after reset");

  initial begin
    repeat (5) @(posedge periph_clk);
    reset_i <= 1'b0;
    while (rsp_count < TOTAL_REQS && cycles < TIMEOUT_CYCLES) begin
      @(posedge periph_clk);
    end
    timed_out = rsp_count < TOTAL_REQS;
    if (timed_out) begin
      $display("ERROR: timeout after %0d cycles with %0d of %0d responses returned",
               cycles, rsp_count, TOTAL_REQS);
    end
    $display("Responses %0d of %0d, mismatches %0d, timeouts %0d",
             rsp_count, TOTAL_REQS, errors, int'(timed_out));
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/txn_mux_pkg.sv
src/port_arbiter.sv
src/id_remap.sv
src/txn_mux_top.sv
testbench/tb_txn_mux.sv

//--- Makefile
BUILD = build

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f verilog.f --top-module tb_txn_mux \
		-Mdir $(BUILD) -o tb_txn_mux
	./$(BUILD)/tb_txn_mux | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(BUILD)
